// File: design/sparkle_geom_pkg.sv
package sparkle_geom_pkg;

	typedef logic [8:0] row_t; // screen row
	typedef logic [9:0] col_t; // screen column

	typedef struct packed
	{
		row_t row;
		col_t col;
	} scan_pos_t;

	localparam int SPRITE_SIZE = 20; // window edge in pixels

	typedef logic [4:0] spr_idx_t; // row or column offset inside a sprite

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// fixed window origins per mode
	localparam scan_pos_t PLAY_ORG_2  = '{row: 9'd45,  col: 10'd530};
	localparam scan_pos_t PLAY_ORG_3  = '{row: 9'd90,  col: 10'd590};
	localparam scan_pos_t PLAY_ORG_4  = '{row: 9'd400, col: 10'd555};
	localparam scan_pos_t BOARD_ORG_0 = '{row: 9'd45,  col: 10'd120};
	localparam scan_pos_t BOARD_ORG_1 = '{row: 9'd220, col: 10'd172};
	localparam scan_pos_t BOARD_ORG_2 = '{row: 9'd290, col: 10'd120};
	localparam scan_pos_t BOARD_ORG_3 = '{row: 9'd350, col: 10'd200};

endpackage

// File: design/sparkle_anim_pkg.sv
package sparkle_anim_pkg;

	localparam int N_SLOTS  = 5; // sprite slots on screen
	localparam int N_FRAMES = 4; // animation frames in memory

	typedef logic [1:0] frame_t;

	// memory row: frame * 20 + sprite row
	typedef logic [6:0] rom_addr_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// per-slot result of the window test
	typedef struct packed
	{
		logic                       hit;
		sparkle_geom_pkg::spr_idx_t spr_row;
		sparkle_geom_pkg::spr_idx_t spr_col;
	} slot_hit_t;

endpackage

// File: design/raster_scan.sv
module raster_scan #(
	parameter int H_TOTAL = 800,
	parameter int V_TOTAL = 525
) (
	input  logic                       clk,
	input  logic                       rst,
	output sparkle_geom_pkg::scan_pos_t scan,
	output logic                       frame_start
);

	sparkle_geom_pkg::col_t col_cnt;
	logic [9:0]             row_cnt; // one bit wider than row_t for tall blanking
	logic                   last_col;
	logic                   last_row;

	assign last_col = (col_cnt == sparkle_geom_pkg::col_t'(H_TOTAL - 1));
	assign last_row = (row_cnt == 10'(V_TOTAL - 1));

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			col_cnt     <= '0;
			row_cnt     <= '0;
			frame_start <= 1'b0;
		end
		else
		begin
			frame_start <= last_col && last_row; // next position is 0,0
			if (last_col)
			begin
				col_cnt <= '0;
				row_cnt <= last_row ? 10'd0 : row_cnt + 10'd1;
			end
			else
				col_cnt <= col_cnt + 10'd1;
		end
	end

	// blank rows past 511 park at 511, far below any window
	assign scan = '{row: row_cnt[9] ? 9'h1ff : row_cnt[8:0], col: col_cnt};

endmodule

// File: design/sprite_window.sv
module sprite_window (
	input  logic                        clk,
	input  logic                        rst,
	input  sparkle_geom_pkg::scan_pos_t scan,
	input  sparkle_geom_pkg::scan_pos_t origin,
	input  logic                        en,
	output sparkle_anim_pkg::slot_hit_t hit
);

	sparkle_geom_pkg::row_t row_diff;
	sparkle_geom_pkg::col_t col_diff;
	logic                   in_win;

	// above or left of the origin wraps to a large value and fails the compare
	assign row_diff = scan.row - origin.row;
	assign col_diff = scan.col - origin.col;

	assign in_win = en
		&& (row_diff < sparkle_geom_pkg::row_t'(sparkle_geom_pkg::SPRITE_SIZE))
		&& (col_diff < sparkle_geom_pkg::col_t'(sparkle_geom_pkg::SPRITE_SIZE));

	always_ff @(posedge clk)
	begin
		hit.spr_row <= row_diff[4:0];
		hit.spr_col <= col_diff[4:0];
		if (rst)
			hit.hit <= 1'b0;
		else
			hit.hit <= in_win;
	end

	a_offs_in_window: assert property (@(posedge clk) disable iff (rst)
		hit.hit |-> (hit.spr_row < 5'(sparkle_geom_pkg::SPRITE_SIZE)
			&& hit.spr_col < 5'(sparkle_geom_pkg::SPRITE_SIZE)));

endmodule

// File: design/anim_sequencer.sv
module anim_sequencer #(
	parameter int STEP_FRAMES = 1,
	parameter int REVERSE     = 0
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     frame_start,
	output sparkle_anim_pkg::frame_t frame
);

	localparam int CNT_W = (STEP_FRAMES > 1) ? $clog2(STEP_FRAMES) : 1;

	logic [CNT_W-1:0] step_cnt; // screen frames since the last step
	logic             step_now;

	assign step_now = frame_start && (step_cnt == CNT_W'(STEP_FRAMES - 1));

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			step_cnt <= '0;
			frame    <= '0;
		end
		else if (frame_start)
		begin
			if (step_now)
			begin
				step_cnt <= '0;
				// 2-bit index wraps modulo 4 on its own
				if (REVERSE != 0)
					frame <= frame - 2'd1;
				else
					frame <= frame + 2'd1;
			end
			else
				step_cnt <= step_cnt + CNT_W'(1);
		end
	end

endmodule

// File: design/sparkle_ctrl.sv
module sparkle_ctrl (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         frame_start,
	input  logic                         leaderboard,
	input  logic                         two_player_mode,
	input  sparkle_geom_pkg::scan_pos_t  p1_origin,
	input  sparkle_geom_pkg::scan_pos_t  p2_origin,
	input  sparkle_anim_pkg::slot_hit_t  slot_hit [sparkle_anim_pkg::N_SLOTS],
	input  sparkle_anim_pkg::frame_t     slot_frame [sparkle_anim_pkg::N_SLOTS],
	output sparkle_geom_pkg::scan_pos_t  origin [sparkle_anim_pkg::N_SLOTS],
	output logic [sparkle_anim_pkg::N_SLOTS-1:0] en,
	output sparkle_anim_pkg::rom_addr_t  rom_addr,
	output sparkle_geom_pkg::spr_idx_t   col_sel,
	output logic                         pix_on
);

	typedef enum logic [1:0] {mode_play_one, mode_play_two, mode_board} mode_t;

	mode_t                       mode_q;
	sparkle_geom_pkg::scan_pos_t p1_q;
	sparkle_geom_pkg::scan_pos_t p2_q;
	logic                        win_hit;
	sparkle_anim_pkg::frame_t    win_frame;
	sparkle_geom_pkg::spr_idx_t  win_row;
	sparkle_geom_pkg::spr_idx_t  win_col;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// mode and player origins, frame-synchronous
	always_ff @(posedge clk)
	begin
		if (rst)
			mode_q <= mode_play_one;
		else if (frame_start)
		begin
			if (leaderboard)
				mode_q <= mode_board; // leaderboard wins over player count
			else if (two_player_mode)
				mode_q <= mode_play_two;
			else
				mode_q <= mode_play_one;
		end
	end

	// also loaded in reset so the first frame has defined windows
	always_ff @(posedge clk)
	begin
		if (rst || frame_start)
		begin
			p1_q <= p1_origin;
			p2_q <= p2_origin;
		end
	end

	always_comb
	begin
		origin[0] = p1_q;
		origin[1] = p2_q;
		origin[2] = sparkle_geom_pkg::PLAY_ORG_2;
		origin[3] = sparkle_geom_pkg::PLAY_ORG_3;
		origin[4] = sparkle_geom_pkg::PLAY_ORG_4;
		case (mode_q)
			mode_play_one: en = 5'b10011;
			mode_play_two: en = 5'b11111;
			mode_board:
			begin
				origin[0] = sparkle_geom_pkg::BOARD_ORG_0;
				origin[1] = sparkle_geom_pkg::BOARD_ORG_1;
				origin[2] = sparkle_geom_pkg::BOARD_ORG_2;
				origin[3] = sparkle_geom_pkg::BOARD_ORG_3;
				en        = 5'b01111; // slot 4 off on the leaderboard
			end
			default: en = 5'b00000;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// highest-numbered hitting slot wins
	always_comb
	begin
		win_hit   = 1'b0;
		win_frame = '0;
		win_row   = '0;
		win_col   = '0;
		for (int i = 0; i < sparkle_anim_pkg::N_SLOTS; i++)
		begin
			if (slot_hit[i].hit)
			begin
				win_hit   = 1'b1;
				win_frame = slot_frame[i];
				win_row   = slot_hit[i].spr_row;
				win_col   = slot_hit[i].spr_col;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		rom_addr <= sparkle_anim_pkg::rom_addr_t'(win_frame)
			* sparkle_anim_pkg::rom_addr_t'(sparkle_geom_pkg::SPRITE_SIZE)
			+ sparkle_anim_pkg::rom_addr_t'(win_row);
		col_sel  <= win_col;
		if (rst)
			pix_on <= 1'b0;
		else
			pix_on <= win_hit;
	end

	a_addr_range: assert property (@(posedge clk) disable iff (rst)
		rom_addr < sparkle_anim_pkg::rom_addr_t'(sparkle_anim_pkg::N_FRAMES
			* sparkle_geom_pkg::SPRITE_SIZE));

endmodule

// File: design/sparkle_rom.sv
module sparkle_rom (
	input  logic                        clk,
	input  sparkle_anim_pkg::rom_addr_t rom_addr,
	input  sparkle_geom_pkg::spr_idx_t  col_sel,
	input  logic                        pix_on,
	output logic                        sparkle,
	output logic                        sparkle_on
);

	localparam int DEPTH = sparkle_anim_pkg::N_FRAMES * sparkle_geom_pkg::SPRITE_SIZE;

	// one word per sprite row, bit 0 is column offset 0
	logic [sparkle_geom_pkg::SPRITE_SIZE-1:0] mem [DEPTH];

	initial
	begin
		$readmemh("sparkle_frames.mem", mem);
	end

	always_ff @(posedge clk)
	begin
		sparkle    <= pix_on & mem[rom_addr][col_sel];
		sparkle_on <= pix_on;
	end

endmodule

// File: design/sparkle_overlay.sv
module sparkle_overlay #(
	parameter int H_TOTAL     = 800,
	parameter int V_TOTAL     = 525,
	parameter int STEP_FRAMES = 8
) (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        leaderboard,
	input  logic                        two_player_mode,
	input  sparkle_geom_pkg::scan_pos_t p1_origin,
	input  sparkle_geom_pkg::scan_pos_t p2_origin,
	output sparkle_geom_pkg::scan_pos_t scan,
	output logic                        frame_start,
	output logic                        sparkle,
	output logic                        sparkle_on
);

	sparkle_anim_pkg::slot_hit_t  slot_hit [sparkle_anim_pkg::N_SLOTS];
	sparkle_anim_pkg::frame_t     slot_frame [sparkle_anim_pkg::N_SLOTS];
	sparkle_geom_pkg::scan_pos_t  slot_origin [sparkle_anim_pkg::N_SLOTS];
	logic [sparkle_anim_pkg::N_SLOTS-1:0] slot_en;
	sparkle_anim_pkg::rom_addr_t  rom_addr;
	sparkle_geom_pkg::spr_idx_t   col_sel;
	logic                         pix_on;

	raster_scan #(.H_TOTAL(H_TOTAL), .V_TOTAL(V_TOTAL)) scan_i (
		.clk, .rst, .scan, .frame_start
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// per-slot window test and animation
	for (genvar i = 0; i < sparkle_anim_pkg::N_SLOTS; i++)
	begin : g_slot
		sprite_window win_i (
			.clk, .rst, .scan,
			.origin (slot_origin[i]),
			.en     (slot_en[i]),
			.hit    (slot_hit[i])
		);

		// slot 3 runs three times slower, slots 3 and 4 run backwards
		anim_sequencer #(
			.STEP_FRAMES ((i == 3) ? 3 * STEP_FRAMES : STEP_FRAMES),
			.REVERSE     ((i >= 3) ? 1 : 0)
		) seq_i (
			.clk, .rst, .frame_start,
			.frame (slot_frame[i])
		);
	end

	sparkle_ctrl ctrl_i (
		.clk, .rst, .frame_start, .leaderboard, .two_player_mode,
		.p1_origin, .p2_origin, .slot_hit, .slot_frame,
		.origin (slot_origin),
		.en     (slot_en),
		.rom_addr, .col_sel, .pix_on
	);

	sparkle_rom rom_i (
		.clk, .rom_addr, .col_sel, .pix_on, .sparkle, .sparkle_on
	);

endmodule

// File: tb/tb_sparkle_overlay.sv
module tb_sparkle_overlay;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int     H_TOTAL      = 660;
	localparam int     V_TOTAL      = 490;
	localparam int     PIPE_DEPTH   = 3;
	localparam int     N_STEPS      = 8;
	localparam int     MODE_ONE     = 0;
	localparam int     MODE_TWO     = 1;
	localparam int     MODE_BOARD   = 2;
	localparam longint FRAME_CYCLES = H_TOTAL * V_TOTAL;
	localparam longint LIMIT_NS     = (12 * FRAME_CYCLES + 2000) * 8;

	logic                        clk;
	logic                        rst;
	logic                        leaderboard;
	logic                        two_player_mode;
	sparkle_geom_pkg::scan_pos_t p1_origin;
	sparkle_geom_pkg::scan_pos_t p2_origin;
	sparkle_geom_pkg::scan_pos_t scan;
	logic                        frame_start;
	logic                        sparkle;
	logic                        sparkle_on;

	logic [19:0] rom_img [80];
	string       step_name; // label of the inputs being driven

	// reference model state
	int                          model_mode;
	sparkle_geom_pkg::scan_pos_t model_p1;
	sparkle_geom_pkg::scan_pos_t model_p2;
	int                          model_frame [5];
	int                          slow_cnt;
	string                       model_name;
	int                          exp_row;
	int                          exp_col;
	logic                        exp_fs;
	logic [1:0]                  exp_q [$]; // {sparkle_on, sparkle}
	string                       name_q [$];

	sparkle_overlay #(.H_TOTAL(H_TOTAL), .V_TOTAL(V_TOTAL), .STEP_FRAMES(1)) dut_i (
		.clk, .rst, .leaderboard, .two_player_mode, .p1_origin, .p2_origin,
		.scan, .frame_start, .sparkle, .sparkle_on
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	initial $readmemh("sparkle_frames.mem", rom_img);

	task automatic report_mismatch(input string test, input int expected, input int actual);
		$display("FAIL %s expected %0d actual %0d", test, expected, actual);
		$display("Simulation failed");
		$fatal(1, "mismatch in %s", test);
	endtask

	task automatic report_error(input string what);
		$display("ERROR %s", what);
		$display("Simulation failed");
		$fatal(1, "%s", what);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference model
	function automatic logic [1:0] expected_pixel(input int mode,
		input sparkle_geom_pkg::scan_pos_t p1, input sparkle_geom_pkg::scan_pos_t p2,
		input int frm [5], input int row, input int col);
		int         org_row [5];
		int         org_col [5];
		logic [4:0] en;
		int         win;
		int         addr;
		int         dc;
		org_row = '{int'(p1.row), int'(p2.row), 45, 90, 400};
		org_col = '{int'(p1.col), int'(p2.col), 530, 590, 555};
		en      = (mode == MODE_ONE) ? 5'b10011 : 5'b11111;
		if (mode == MODE_BOARD)
		begin
			org_row = '{45, 220, 290, 350, 0};
			org_col = '{120, 172, 120, 200, 0};
			en      = 5'b01111;
		end
		win = -1;
		for (int i = 0; i < 5; i++)
		begin
			if (en[i] && row >= org_row[i] && row < org_row[i] + 20
				&& col >= org_col[i] && col < org_col[i] + 20)
				win = i; // later slot overrides
		end
		if (win < 0)
			return 2'b00;
		addr = frm[win] * 20 + (row - org_row[win]);
		dc   = col - org_col[win];
		return {1'b1, rom_img[addr][dc]};
	endfunction

	task automatic reset_model();
		exp_row    = 0;
		exp_col    = 0;
		exp_fs     = 1'b0;
		model_mode = MODE_ONE;
		model_p1   = p1_origin;
		model_p2   = p2_origin;
		model_name = step_name;
		slow_cnt   = 0;
		for (int i = 0; i < 5; i++)
			model_frame[i] = 0;
		exp_q.delete();
		name_q.delete();
	endtask

	// new mode, origins and frame indices take hold at each frame start
	task automatic latch_frame();
		model_mode = leaderboard ? MODE_BOARD : (two_player_mode ? MODE_TWO : MODE_ONE);
		model_p1   = p1_origin;
		model_p2   = p2_origin;
		model_name = step_name;
		for (int i = 0; i < 3; i++)
			model_frame[i] = (model_frame[i] + 1) % 4;
		model_frame[4] = (model_frame[4] + 3) % 4;
		slow_cnt++;
		if (slow_cnt == 3)
		begin
			slow_cnt       = 0;
			model_frame[3] = (model_frame[3] + 3) % 4;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// comparison, sampled on the falling edge
	always @(negedge clk)
	begin
		logic [1:0] want;
		string      want_name;
		if (rst !== 1'b0)
			reset_model();
		else
		begin
			assert (scan.row == sparkle_geom_pkg::row_t'(exp_row))
				else report_mismatch("raster_row", exp_row, int'(scan.row));
			assert (scan.col == sparkle_geom_pkg::col_t'(exp_col))
				else report_mismatch("raster_col", exp_col, int'(scan.col));
			assert (frame_start == exp_fs)
				else report_mismatch("frame_start", int'(exp_fs), int'(frame_start));
			exp_q.push_back(expected_pixel(model_mode, model_p1, model_p2, model_frame,
				exp_row, exp_col));
			name_q.push_back(model_name);
			if (exp_q.size() > PIPE_DEPTH)
			begin
				want      = exp_q.pop_front();
				want_name = name_q.pop_front();
				assert (sparkle_on == want[1])
					else report_mismatch({want_name, " sparkle_on"}, int'(want[1]),
						int'(sparkle_on));
				assert (sparkle == want[0])
					else report_mismatch({want_name, " sparkle"}, int'(want[0]),
						int'(sparkle));
			end
			if (exp_fs)
				latch_frame();
			exp_fs = 1'b0;
			if (exp_col == H_TOTAL - 1)
			begin
				exp_col = 0;
				if (exp_row == V_TOTAL - 1)
				begin
					exp_row = 0;
					exp_fs  = 1'b1;
				end
				else
					exp_row++;
			end
			else
				exp_col++;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus
	function automatic sparkle_geom_pkg::scan_pos_t make_origin(input int r, input int c);
		sparkle_geom_pkg::scan_pos_t pos;
		pos.row = sparkle_geom_pkg::row_t'(r);
		pos.col = sparkle_geom_pkg::col_t'(c);
		return pos;
	endfunction

	function automatic sparkle_geom_pkg::scan_pos_t random_origin();
		sparkle_geom_pkg::scan_pos_t pos;
		pos.row = sparkle_geom_pkg::row_t'(1 + $urandom % 460);
		pos.col = sparkle_geom_pkg::col_t'($urandom % 621);
		return pos;
	endfunction

	task automatic wait_frame_start();
		do
			@(negedge clk);
		while (frame_start !== 1'b1);
	endtask

	task automatic wait_mid_frame();
		do
			@(negedge clk);
		while (scan.row != 9'd240);
	endtask

	task automatic drive_inputs(input string name, input logic lb, input logic two,
		input sparkle_geom_pkg::scan_pos_t a, input sparkle_geom_pkg::scan_pos_t b);
		step_name       = name;
		leaderboard     <= lb;
		two_player_mode <= two;
		p1_origin       <= a;
		p2_origin       <= b;
	endtask

	task automatic apply_step(input int k);
		sparkle_geom_pkg::scan_pos_t r1;
		sparkle_geom_pkg::scan_pos_t r2;
		r1 = random_origin();
		r2 = random_origin();
		case (k)
			0: drive_inputs("one_player", 1'b0, 1'b0, r1, r2);
			// three windows stacked around slot 2
			1: drive_inputs("two_player_overlap", 1'b0, 1'b1, make_origin(40, 525),
				make_origin(50, 540));
			2: drive_inputs("two_player_corner", 1'b0, 1'b1, make_origin(85, 585),
				make_origin(395, 550));
			3: drive_inputs("leaderboard", 1'b1, 1'b1, r1, r2);
			4: drive_inputs("leaderboard_one", 1'b1, 1'b0, r1, r2);
			5: drive_inputs("mid_frame_two", 1'b0, 1'b1, r1, r2);
			6: drive_inputs("mid_frame_board", 1'b1, 1'b0, r1, r2);
			default: drive_inputs("mid_frame_one", 1'b0, 1'b0, r1, r2);
		endcase
	endtask

	initial
	begin
		void'($urandom(32'hbcf1));
		rst             = 1'b1;
		leaderboard     = 1'b0;
		two_player_mode = 1'b0;
		p1_origin       = random_origin();
		p2_origin       = random_origin();
		step_name       = "reset_frame";
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		for (int k = 0; k < N_STEPS; k++)
		begin
			wait_frame_start();
			if (k >= 5)
				wait_mid_frame(); // last steps change inputs halfway down the screen
			@(posedge clk);
			apply_step(k);
		end
		wait_frame_start(); // last step latched
		wait_frame_start(); // and shown for a whole frame
		repeat (PIPE_DEPTH + 2) @(posedge clk);
		$display("Simulation passed");
		$finish;
	end

	initial
	begin
		#(LIMIT_NS);
		report_error("watchdog timeout, the run did not reach its end");
	end

endmodule

// File: flist.f
design/sparkle_geom_pkg.sv
design/sparkle_anim_pkg.sv
design/raster_scan.sv
design/sprite_window.sv
design/anim_sequencer.sv
design/sparkle_ctrl.sv
design/sparkle_rom.sv
design/sparkle_overlay.sv
tb/tb_sparkle_overlay.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_sparkle_overlay \
	-f flist.f \
	--Mdir "$OBJ" -o sim_bin
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$OBJ/sim_bin" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
exit 0

// File: sparkle_frames.mem
// one 20-bit word per sprite row, bit 0 is column offset 0
// rows 0-19 frame 0, 20-39 frame 1, 40-59 frame 2, 60-79 frame 3
00000
00400
00400
00e00
00e00
01f00
21f08
0fffe
03ff8
00e00
00e00
03ff8
0fffe
21f08
01f00
00e00
00e00
00400
00400
00000
80001
40002
20004
10008
08010
04020
02040
01080
00900
00600
00600
00900
01080
02040
04020
08010
10008
20004
40002
80001
00000
08010
00000
00420
02004
00000
40a00
00000
01008
20100
00840
00000
04002
00000
80201
00000
00420
10000
00008
00000
11111
22222
44444
88888
11111
22222
44444
88888
11111
22222
44444
88888
11111
22222
44444
88888
11111
22222
44444
88888
